/* design/fp_macros.svh */
`ifndef FP_MACROS_SVH
`define FP_MACROS_SVH

// binary32 field widths and bias
`define FP_EXP_W 8
`define FP_MAN_W 23
`define FP_BIAS 127

// hidden bit + fraction + two extra bits, sticky is carried apart
`define FP_WORK_W 26

// quotient bits produced by the divider
`define FP_DIV_STEPS 26

`endif

/* design/fp_types_pkg.sv */
`include "fp_macros.svh"

package fp_types_pkg;

    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_MAN_W-1:0]  frac;
    } float32_t;

    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } fp_class_e;

    // exponent stays biased, significand has the hidden bit attached
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_MAN_W:0]    sig;
        fp_class_e             cls;
    } fp_operand_t;

    typedef struct packed {
        logic invalid;
        logic div_by_zero;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    typedef enum logic [1:0] {
        RM_RNE = 2'd0,
        RM_RTZ = 2'd1,
        RM_RUP = 2'd2,
        RM_RDN = 2'd3
    } round_mode_e;

endpackage

/* design/fp_ops_pkg.sv */
`include "fp_macros.svh"

package fp_ops_pkg;

    typedef enum logic {
        OP_MUL = 1'b0,
        OP_DIV = 1'b1
    } fp_op_e;

    typedef struct packed {
        fp_op_e                    op;
        fp_types_pkg::float32_t    a;
        fp_types_pkg::float32_t    b;
        fp_types_pkg::round_mode_e rm;
    } fp_req_t;

    typedef enum logic [1:0] {
        SPC_NONE = 2'd0,
        SPC_ZERO = 2'd1,
        SPC_INF  = 2'd2,
        SPC_QNAN = 2'd3
    } fp_special_e;

    // result of a core before rounding, leading one at the top of sig
    typedef struct packed {
        logic                      sign;
        logic signed [9:0]         exp;
        logic [`FP_WORK_W-1:0]     sig;
        logic                      sticky;
        fp_special_e               special;
        logic                      invalid;
        logic                      div_by_zero;
        fp_types_pkg::round_mode_e rm;
    } fp_raw_t;

endpackage

/* design/fp_unpack.sv */
module fp_unpack (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  fp_ops_pkg::fp_req_t       req,
    input  logic                      busy,
    output logic                      op_valid,
    output fp_ops_pkg::fp_op_e        op,
    output fp_types_pkg::round_mode_e rm,
    output fp_types_pkg::fp_operand_t opa,
    output fp_types_pkg::fp_operand_t opb
);

    logic accept;

    function automatic fp_types_pkg::fp_operand_t classify(fp_types_pkg::float32_t f);
        fp_types_pkg::fp_operand_t o;
        o.sign = f.sign;
        o.exp  = f.exp;
        o.sig  = {1'b1, f.frac};
        if (f.exp == '0) begin
            // zero and subnormal both land here
            o.cls = fp_types_pkg::CLS_ZERO;
            o.exp = '0;
            o.sig = '0;
        end else if (f.exp == '1) begin
            o.cls = (f.frac == '0) ? fp_types_pkg::CLS_INF : fp_types_pkg::CLS_NAN;
        end else begin
            o.cls = fp_types_pkg::CLS_NORMAL;
        end
        return o;
    endfunction

    // a divide still sitting in op_valid has not raised busy yet
    assign accept = req_valid && !busy && !(op_valid && op == fp_ops_pkg::OP_DIV);

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op  <= req.op;
            rm  <= req.rm;
            opa <= classify(req.a);
            opb <= classify(req.b);
        end
    end

endmodule

/* design/fp_mul_core.sv */
`include "fp_macros.svh"

module fp_mul_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      op_valid,
    input  fp_ops_pkg::fp_op_e        op,
    input  fp_types_pkg::round_mode_e rm,
    input  fp_types_pkg::fp_operand_t opa,
    input  fp_types_pkg::fp_operand_t opb,
    output logic                      raw_valid,
    output fp_ops_pkg::fp_raw_t       raw
);

    localparam int PROD_W = 2 * (`FP_MAN_W + 1);

    // stage one registers
    logic                      s1_valid;
    logic                      s1_sign;
    logic signed [9:0]         s1_exp;
    logic [PROD_W-1:0]         s1_prod;
    fp_types_pkg::fp_class_e   s1_cls_a;
    fp_types_pkg::fp_class_e   s1_cls_b;
    fp_types_pkg::round_mode_e s1_rm;

    // stage two decode
    logic                      nan_in;
    logic                      inf_in;
    logic                      zero_in;
    fp_ops_pkg::fp_raw_t       nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            raw_valid <= 1'b0;
        end else begin
            s1_valid  <= op_valid && op == fp_ops_pkg::OP_MUL;
            raw_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_sign  <= opa.sign ^ opb.sign;
        s1_exp   <= 10'(opa.exp) + 10'(opb.exp) - 10'(`FP_BIAS);
        s1_prod  <= opa.sig * opb.sig;
        s1_cls_a <= opa.cls;
        s1_cls_b <= opb.cls;
        s1_rm    <= rm;
    end

    always_comb begin
        nan_in  = s1_cls_a == fp_types_pkg::CLS_NAN || s1_cls_b == fp_types_pkg::CLS_NAN;
        inf_in  = s1_cls_a == fp_types_pkg::CLS_INF || s1_cls_b == fp_types_pkg::CLS_INF;
        zero_in = s1_cls_a == fp_types_pkg::CLS_ZERO || s1_cls_b == fp_types_pkg::CLS_ZERO;

        nxt.sign        = s1_sign;
        nxt.rm          = s1_rm;
        nxt.div_by_zero = 1'b0;
        nxt.invalid     = 1'b0;
        // product of two 1.x values lies in [1,4)
        if (s1_prod[PROD_W-1]) begin
            nxt.exp    = s1_exp + 10'sd1;
            nxt.sig    = s1_prod[PROD_W-1 -: `FP_WORK_W];
            nxt.sticky = |s1_prod[PROD_W-`FP_WORK_W-1:0];
        end else begin
            nxt.exp    = s1_exp;
            nxt.sig    = s1_prod[PROD_W-2 -: `FP_WORK_W];
            nxt.sticky = |s1_prod[PROD_W-`FP_WORK_W-2:0];
        end

        if (nan_in || (zero_in && inf_in)) begin
            nxt.special = fp_ops_pkg::SPC_QNAN;
            nxt.invalid = 1'b1;
        end else if (inf_in) begin
            nxt.special = fp_ops_pkg::SPC_INF;
        end else if (zero_in) begin
            nxt.special = fp_ops_pkg::SPC_ZERO;
        end else begin
            nxt.special = fp_ops_pkg::SPC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        raw <= nxt;
    end

endmodule

/* design/fp_div_core.sv */
`include "fp_macros.svh"

module fp_div_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      op_valid,
    input  fp_ops_pkg::fp_op_e        op,
    input  fp_types_pkg::round_mode_e rm,
    input  fp_types_pkg::fp_operand_t opa,
    input  fp_types_pkg::fp_operand_t opb,
    output logic                      busy,
    output logic                      raw_valid,
    output fp_ops_pkg::fp_raw_t       raw
);

    localparam int CNT_W = $clog2(`FP_DIV_STEPS);

    typedef enum logic [1:0] {S_IDLE, S_ITER, S_NORM} state_e;

    // one restoring step: next remainder and the quotient bit
    typedef struct packed {
        logic [`FP_MAN_W+1:0] rem;
        logic                 q;
    } step_t;

    state_e                     state;
    logic [CNT_W-1:0]           cnt;
    logic [`FP_MAN_W+1:0]       rem;
    logic [`FP_MAN_W:0]         divisor;
    logic [`FP_WORK_W-1:0]      quo;
    logic                       sign;
    logic signed [9:0]          exp;
    fp_ops_pkg::fp_special_e    special;
    logic                       invalid;
    logic                       dbz;
    fp_types_pkg::round_mode_e  rm_q;
    logic                       start;
    step_t                      first;
    step_t                      step;

    function automatic step_t div_step(logic [`FP_MAN_W+1:0] r, logic [`FP_MAN_W:0] d);
        step_t                s;
        logic [`FP_MAN_W+1:0] diff;
        diff = r - {1'b0, d};
        if (r >= {1'b0, d}) begin
            s.rem = {diff[`FP_MAN_W:0], 1'b0};
            s.q   = 1'b1;
        end else begin
            s.rem = {r[`FP_MAN_W:0], 1'b0};
            s.q   = 1'b0;
        end
        return s;
    endfunction

    assign start = state == S_IDLE && op_valid && op == fp_ops_pkg::OP_DIV;
    // the accepting edge already produces quotient bit one
    assign first = div_step({1'b0, opa.sig}, opb.sig);
    assign step  = div_step(rem, divisor);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            cnt       <= '0;
            busy      <= 1'b0;
            raw_valid <= 1'b0;
        end else begin
            raw_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_ITER;
                        cnt   <= CNT_W'(1);
                        busy  <= 1'b1;
                    end
                end
                S_ITER: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`FP_DIV_STEPS - 1)) begin
                        state <= S_NORM;
                    end
                end
                default: begin
                    state     <= S_IDLE;
                    busy      <= 1'b0;
                    raw_valid <= 1'b1;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            rem     <= first.rem;
            quo     <= {{(`FP_WORK_W-1){1'b0}}, first.q};
            divisor <= opb.sig;
            sign    <= opa.sign ^ opb.sign;
            exp     <= 10'(opa.exp) - 10'(opb.exp) + 10'(`FP_BIAS);
            rm_q    <= rm;
            invalid <= 1'b0;
            dbz     <= 1'b0;
            if (opa.cls == fp_types_pkg::CLS_NAN || opb.cls == fp_types_pkg::CLS_NAN ||
                (opa.cls == fp_types_pkg::CLS_ZERO && opb.cls == fp_types_pkg::CLS_ZERO) ||
                (opa.cls == fp_types_pkg::CLS_INF && opb.cls == fp_types_pkg::CLS_INF)) begin
                special <= fp_ops_pkg::SPC_QNAN;
                invalid <= 1'b1;
            end else if (opa.cls == fp_types_pkg::CLS_INF) begin
                special <= fp_ops_pkg::SPC_INF;
            end else if (opb.cls == fp_types_pkg::CLS_ZERO) begin
                special <= fp_ops_pkg::SPC_INF;
                dbz     <= 1'b1;
            end else if (opa.cls == fp_types_pkg::CLS_ZERO ||
                         opb.cls == fp_types_pkg::CLS_INF) begin
                special <= fp_ops_pkg::SPC_ZERO;
            end else begin
                special <= fp_ops_pkg::SPC_NONE;
            end
        end else if (state == S_ITER) begin
            rem <= step.rem;
            quo <= {quo[`FP_WORK_W-2:0], step.q};
        end
    end

    // normalize: quotient lies in (0.5, 2)
    always_ff @(posedge clk) begin
        if (state == S_NORM) begin
            raw.sign        <= sign;
            raw.sticky      <= |rem;
            raw.special     <= special;
            raw.invalid     <= invalid;
            raw.div_by_zero <= dbz;
            raw.rm          <= rm_q;
            if (quo[`FP_WORK_W-1]) begin
                raw.sig <= quo;
                raw.exp <= exp;
            end else begin
                raw.sig <= {quo[`FP_WORK_W-2:0], 1'b0};
                raw.exp <= exp - 10'sd1;
            end
        end
    end

    a_no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        op_valid |-> !busy);

    // two normal significands always leave a leading one in the top two bits
    a_quotient_in_range: assert property (@(posedge clk) disable iff (rst)
        (state == S_NORM && special == fp_ops_pkg::SPC_NONE) |->
            (quo[`FP_WORK_W-1] || quo[`FP_WORK_W-2]));

endmodule

/* design/fp_round.sv */
`include "fp_macros.svh"

module fp_round (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mul_valid,
    input  logic                   div_valid,
    input  fp_ops_pkg::fp_raw_t    mul_raw,
    input  fp_ops_pkg::fp_raw_t    div_raw,
    output logic                   res_valid,
    output fp_types_pkg::float32_t res,
    output fp_types_pkg::fp_flags_t flags
);

    fp_ops_pkg::fp_raw_t     sel;
    logic                    lsb;
    logic                    guard;
    logic                    rest;
    logic                    lost;
    logic                    round_up;
    logic [`FP_MAN_W+1:0]    mant;
    logic                    carry;
    logic signed [9:0]       exp_r;
    logic                    to_max;
    fp_types_pkg::float32_t  res_d;
    fp_types_pkg::fp_flags_t flags_d;

    assign sel = mul_valid ? mul_raw : div_raw;

    always_comb begin
        lsb   = sel.sig[2];
        guard = sel.sig[1];
        rest  = sel.sig[0] | sel.sticky;
        lost  = guard | rest;

        case (sel.rm)
            fp_types_pkg::RM_RNE: round_up = guard & (rest | lsb);
            fp_types_pkg::RM_RTZ: round_up = 1'b0;
            fp_types_pkg::RM_RUP: round_up = !sel.sign & lost;
            default:              round_up = sel.sign & lost;
        endcase

        mant  = {1'b0, sel.sig[`FP_WORK_W-1:2]} + {{(`FP_MAN_W+1){1'b0}}, round_up};
        carry = mant[`FP_MAN_W+1];
        exp_r = sel.exp + {9'd0, carry};
        // directed modes pointing toward zero clamp to the largest finite
        to_max = sel.rm == fp_types_pkg::RM_RTZ ||
                 (sel.rm == fp_types_pkg::RM_RUP && sel.sign) ||
                 (sel.rm == fp_types_pkg::RM_RDN && !sel.sign);

        flags_d             = '0;
        flags_d.invalid     = sel.invalid;
        flags_d.div_by_zero = sel.div_by_zero;
        res_d.sign          = sel.sign;
        res_d.exp           = exp_r[`FP_EXP_W-1:0];
        res_d.frac          = carry ? mant[`FP_MAN_W:1] : mant[`FP_MAN_W-1:0];

        case (sel.special)
            fp_ops_pkg::SPC_ZERO: begin
                res_d.exp  = '0;
                res_d.frac = '0;
            end
            fp_ops_pkg::SPC_INF: begin
                res_d.exp  = '1;
                res_d.frac = '0;
            end
            fp_ops_pkg::SPC_QNAN: begin
                // canonical quiet nan, positive
                res_d.sign = 1'b0;
                res_d.exp  = '1;
                res_d.frac = {1'b1, {(`FP_MAN_W-1){1'b0}}};
            end
            default: begin
                flags_d.inexact = lost;
                if ($signed(exp_r) >= 10'sd255) begin
                    flags_d.overflow = 1'b1;
                    flags_d.inexact  = 1'b1;
                    if (to_max) begin
                        res_d.exp  = 8'hfe;
                        res_d.frac = '1;
                    end else begin
                        res_d.exp  = '1;
                        res_d.frac = '0;
                    end
                end else if ($signed(exp_r) <= 10'sd0) begin
                    // tiny after rounding, flushed to signed zero
                    flags_d.underflow = 1'b1;
                    flags_d.inexact   = 1'b1;
                    res_d.exp         = '0;
                    res_d.frac        = '0;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= mul_valid | div_valid;
        end
    end

    always_ff @(posedge clk) begin
        res   <= res_d;
        flags <= flags_d;
    end

    a_one_core_at_a_time: assert property (@(posedge clk) disable iff (rst)
        !(mul_valid && div_valid));

endmodule

/* design/fp_unit_top.sv */
module fp_unit_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  fp_ops_pkg::fp_req_t     req,
    output logic                    busy,
    output logic                    res_valid,
    output fp_types_pkg::float32_t  res,
    output fp_types_pkg::fp_flags_t flags
);

    logic                      op_valid;
    fp_ops_pkg::fp_op_e        op;
    fp_types_pkg::round_mode_e rm;
    fp_types_pkg::fp_operand_t opa;
    fp_types_pkg::fp_operand_t opb;
    logic                      mul_valid;
    logic                      div_valid;
    fp_ops_pkg::fp_raw_t       mul_raw;
    fp_ops_pkg::fp_raw_t       div_raw;

    fp_unpack i_unpack (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .op_valid  (op_valid),
        .op        (op),
        .rm        (rm),
        .opa       (opa),
        .opb       (opb)
    );

    fp_mul_core i_mul (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op        (op),
        .rm        (rm),
        .opa       (opa),
        .opb       (opb),
        .raw_valid (mul_valid),
        .raw       (mul_raw)
    );

    fp_div_core i_div (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op        (op),
        .rm        (rm),
        .opa       (opa),
        .opb       (opb),
        .busy      (busy),
        .raw_valid (div_valid),
        .raw       (div_raw)
    );

    fp_round i_round (
        .clk       (clk),
        .rst       (rst),
        .mul_valid (mul_valid),
        .div_valid (div_valid),
        .mul_raw   (mul_raw),
        .div_raw   (div_raw),
        .res_valid (res_valid),
        .res       (res),
        .flags     (flags)
    );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
    end

    always begin
        #HALF_PERIOD clk = ~clk;
    end

endmodule

/* test/tb_fp_unit.sv */
`include "fp_macros.svh"

module tb_fp_unit;

    localparam int MUL_LAT = 4;
    localparam int DIV_LAT = 1 + `FP_DIV_STEPS + 2;

    typedef struct packed {
        fp_types_pkg::float32_t  res;
        fp_types_pkg::fp_flags_t flags;
    } result_t;

    // one accepted request as the comparator sees it
    typedef struct packed {
        result_t     want;
        logic [31:0] issued;
        logic [31:0] latency;
    } pending_t;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    fp_ops_pkg::fp_req_t     req;
    logic                    busy;
    logic                    res_valid;
    fp_types_pkg::float32_t  res;
    fp_types_pkg::fp_flags_t flags;

    int       seed;
    int       cycle;
    int       value_errors;
    int       timeout_errors;
    int       protocol_errors;
    pending_t pend_q[$];
    string    name_q[$];
    pending_t got;
    string    got_name;

    tb_clock_gen i_clk (
        .clk (clk)
    );

    fp_unit_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .res_valid (res_valid),
        .res       (res),
        .flags     (flags)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic result_t round_ref(logic sign, int e, logic [25:0] sig, logic sticky,
                                          fp_types_pkg::round_mode_e rm);
        result_t     o;
        logic        guard;
        logic        rest;
        logic        up;
        logic [24:0] mant;
        guard = sig[1];
        rest  = sig[0] | sticky;
        case (rm)
            fp_types_pkg::RM_RNE: up = guard && (rest || sig[2]);
            fp_types_pkg::RM_RTZ: up = 1'b0;
            fp_types_pkg::RM_RUP: up = !sign && (guard || rest);
            default:              up = sign && (guard || rest);
        endcase
        mant = {1'b0, sig[25:2]} + 25'(up);
        if (mant[24]) begin
            mant = mant >> 1;
            e    = e + 1;
        end
        o               = '0;
        o.flags.inexact = guard || rest;
        if (e >= 255) begin
            o.flags.overflow = 1'b1;
            o.flags.inexact  = 1'b1;
            // rounding toward zero for this sign stops at the largest finite value
            if (rm == fp_types_pkg::RM_RTZ || (rm == fp_types_pkg::RM_RUP && sign) ||
                (rm == fp_types_pkg::RM_RDN && !sign)) begin
                o.res = {sign, 8'hfe, 23'h7fffff};
            end else begin
                o.res = {sign, 8'hff, 23'h0};
            end
        end else if (e <= 0) begin
            o.flags.underflow = 1'b1;
            o.flags.inexact   = 1'b1;
            o.res             = {sign, 31'h0};
        end else begin
            o.res = {sign, 8'(e), mant[22:0]};
        end
        return o;
    endfunction

    function automatic result_t ref_fp(fp_ops_pkg::fp_req_t r);
        result_t     o;
        logic        sign;
        logic        a_zero;
        logic        b_zero;
        logic        a_inf;
        logic        b_inf;
        logic        nan;
        logic [23:0] ma;
        logic [23:0] mb;
        logic [47:0] prod;
        logic [49:0] num;
        logic [49:0] quo;
        logic [25:0] sig;
        logic        sticky;
        int          e;
        sign   = r.a.sign ^ r.b.sign;
        a_zero = r.a.exp == 8'h00;
        b_zero = r.b.exp == 8'h00;
        a_inf  = r.a.exp == 8'hff && r.a.frac == '0;
        b_inf  = r.b.exp == 8'hff && r.b.frac == '0;
        nan    = (r.a.exp == 8'hff && r.a.frac != '0) || (r.b.exp == 8'hff && r.b.frac != '0);
        ma     = {1'b1, r.a.frac};
        mb     = {1'b1, r.b.frac};
        o      = '0;
        if (r.op == fp_ops_pkg::OP_MUL) begin
            if (nan || (a_zero && b_inf) || (a_inf && b_zero)) begin
                o.res           = 32'h7fc00000;
                o.flags.invalid = 1'b1;
            end else if (a_inf || b_inf) begin
                o.res = {sign, 31'h7f800000};
            end else if (a_zero || b_zero) begin
                o.res = {sign, 31'h0};
            end else begin
                prod = ma * mb;
                e    = int'(r.a.exp) + int'(r.b.exp) - `FP_BIAS;
                if (prod[47]) begin
                    sig    = prod[47:22];
                    sticky = |prod[21:0];
                    e      = e + 1;
                end else begin
                    sig    = prod[46:21];
                    sticky = |prod[20:0];
                end
                o = round_ref(sign, e, sig, sticky, r.rm);
            end
        end else begin
            if (nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
                o.res           = 32'h7fc00000;
                o.flags.invalid = 1'b1;
            end else if (a_inf) begin
                o.res = {sign, 31'h7f800000};
            end else if (b_zero) begin
                o.res               = {sign, 31'h7f800000};
                o.flags.div_by_zero = 1'b1;
            end else if (a_zero || b_inf) begin
                o.res = {sign, 31'h0};
            end else begin
                e = int'(r.a.exp) - int'(r.b.exp) + `FP_BIAS;
                // scale so the quotient's leading one lands in bit 25
                if (ma >= mb) begin
                    num = 50'(ma) << 25;
                end else begin
                    num = 50'(ma) << 26;
                    e   = e - 1;
                end
                quo    = num / 50'(mb);
                sig    = quo[25:0];
                sticky = (num % 50'(mb)) != 0;
                o      = round_ref(sign, e, sig, sticky, r.rm);
            end
        end
        return o;
    endfunction

    function automatic logic [31:0] random_normal();
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
        sign = 1'($random(seed));
        // mid-range exponents keep random products and quotients normal
        exp  = 8'd96 + 8'($random(seed) & 63);
        frac = 23'($random(seed));
        return {sign, exp, frac};
    endfunction

    function automatic fp_ops_pkg::fp_req_t make_req(fp_ops_pkg::fp_op_e op, logic [31:0] a,
                                                     logic [31:0] b, int rm);
        fp_ops_pkg::fp_req_t r;
        r.op = op;
        r.a  = a;
        r.b  = b;
        r.rm = fp_types_pkg::round_mode_e'(rm[1:0]);
        return r;
    endfunction

    task automatic check_result(input string name, input fp_types_pkg::float32_t want,
                                input fp_types_pkg::float32_t act);
        if (act !== want) begin
            $display("FAIL %s: result expected %h actual %h", name, want, act);
            value_errors++;
        end
    endtask

    task automatic check_flags(input string name, input fp_types_pkg::fp_flags_t want,
                               input fp_types_pkg::fp_flags_t act);
        if (act !== want) begin
            $display("FAIL %s: flags expected %b actual %b", name, want, act);
            value_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int want, input int act);
        if (act != want) begin
            $display("FAIL %s: latency expected %0d actual %0d", name, want, act);
            value_errors++;
        end
    endtask

    // results are sampled half a cycle after the edge that produced them
    always @(negedge clk) begin
        if (!rst && res_valid) begin
            if (pend_q.size() == 0) begin
                $display("unexpected result %h with no request outstanding", res);
                protocol_errors++;
            end else begin
                got      = pend_q.pop_front();
                got_name = name_q.pop_front();
                check_result(got_name, got.want.res, res);
                check_flags(got_name, got.want.flags, flags);
                check_latency(got_name, int'(got.latency), cycle - int'(got.issued));
            end
        end
    end

    task automatic issue(input fp_ops_pkg::fp_req_t r, input string name);
        pending_t p;
        @(negedge clk);
        req_valid = 1'b1;
        req       = r;
        p.want    = ref_fp(r);
        p.issued  = cycle;
        p.latency = (r.op == fp_ops_pkg::OP_MUL) ? MUL_LAT : DIV_LAT;
        pend_q.push_back(p);
        name_q.push_back(name);
    endtask

    task automatic issue_ignored(input fp_ops_pkg::fp_req_t r);
        @(negedge clk);
        req_valid = 1'b1;
        req       = r;
    endtask

    task automatic release_req();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        while (busy !== level && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            $display("timeout: busy did not go to %b within 100 cycles in %s", level, what);
            timeout_errors++;
        end
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (pend_q.size() != 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (pend_q.size() != 0) begin
            $display("timeout: %0d results missing after 100 cycles in %s",
                     pend_q.size(), what);
            timeout_errors++;
            pend_q.delete();
            name_q.delete();
        end
    endtask

    task automatic run_one(input fp_ops_pkg::fp_op_e op, input logic [31:0] a,
                           input logic [31:0] b, input int rm, input string name);
        wait_busy(1'b0, name);
        issue(make_req(op, a, b, rm), name);
        release_req();
        wait_drained(name);
    endtask

    initial begin : stimulus
        int i;
        int m;
        int s;
        seed            = 3644;
        value_errors    = 0;
        timeout_errors  = 0;
        protocol_errors = 0;
        rst             = 1'b1;
        req_valid       = 1'b0;
        req             = '0;
        // five rising edges in reset, released on the following falling edge
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // quiet after reset
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            if (res_valid || busy) begin
                $display("res_valid or busy went high after reset with no request");
                protocol_errors++;
            end
        end

        // back-to-back multiplies, mode rotates every request
        for (i = 0; i < 40; i++) begin
            issue(make_req(fp_ops_pkg::OP_MUL, random_normal(), random_normal(), i % 4),
                  $sformatf("mul_rand_%0d", i));
        end
        release_req();
        wait_drained("random multiplies");

        for (i = 0; i < 24; i++) begin
            run_one(fp_ops_pkg::OP_DIV, random_normal(), random_normal(), i % 4,
                    $sformatf("div_rand_%0d", i));
        end

        run_one(fp_ops_pkg::OP_MUL, 32'h00000000, 32'h3fc00000, 0, "mul_zero");
        run_one(fp_ops_pkg::OP_MUL, 32'h80000000, 32'h3fc00000, 1, "mul_neg_zero");
        run_one(fp_ops_pkg::OP_MUL, 32'h7f800000, 32'hc0400000, 2, "mul_inf");
        run_one(fp_ops_pkg::OP_MUL, 32'h7f800000, 32'h7f800000, 0, "mul_inf_inf");
        run_one(fp_ops_pkg::OP_MUL, 32'h7fc00000, 32'h3f800000, 0, "mul_qnan");
        run_one(fp_ops_pkg::OP_MUL, 32'h3f800000, 32'h7f800001, 3, "mul_snan");
        run_one(fp_ops_pkg::OP_MUL, 32'h00000000, 32'h7f800000, 0, "mul_zero_inf");
        run_one(fp_ops_pkg::OP_MUL, 32'hff800000, 32'h80000000, 1, "mul_inf_zero");
        run_one(fp_ops_pkg::OP_MUL, 32'h00000001, 32'h40000000, 0, "mul_subnormal");
        run_one(fp_ops_pkg::OP_MUL, 32'h807fffff, 32'h7f000000, 2, "mul_subnormal_big");
        run_one(fp_ops_pkg::OP_DIV, 32'h3fc00000, 32'h00000000, 0, "div_by_zero");
        run_one(fp_ops_pkg::OP_DIV, 32'hc0400000, 32'h80000000, 3, "div_by_neg_zero");
        run_one(fp_ops_pkg::OP_DIV, 32'h00000000, 32'h00000000, 0, "div_zero_zero");
        run_one(fp_ops_pkg::OP_DIV, 32'h7f800000, 32'hff800000, 0, "div_inf_inf");
        run_one(fp_ops_pkg::OP_DIV, 32'h00000000, 32'h3f800000, 1, "div_zero_num");
        run_one(fp_ops_pkg::OP_DIV, 32'hbf800000, 32'h7f800000, 0, "div_num_inf");
        run_one(fp_ops_pkg::OP_DIV, 32'h7f800000, 32'h40000000, 2, "div_inf_num");
        run_one(fp_ops_pkg::OP_DIV, 32'h7fc00000, 32'h3f800000, 0, "div_nan_num");
        run_one(fp_ops_pkg::OP_DIV, 32'h3f800000, 32'hffc00001, 0, "div_num_nan");
        run_one(fp_ops_pkg::OP_DIV, 32'h00400000, 32'h3f800000, 0, "div_subnormal_num");
        run_one(fp_ops_pkg::OP_DIV, 32'h3f800000, 32'h00000001, 0, "div_num_subnormal");
        run_one(fp_ops_pkg::OP_DIV, 32'hc0400000, 32'h3fc00000, 0, "div_exact");

        // extreme exponents in every mode and sign
        for (m = 0; m < 4; m++) begin
            for (s = 0; s < 2; s++) begin
                run_one(fp_ops_pkg::OP_MUL, {s[0], 8'hf0, 23'h123456}, 32'h78000000, m,
                        $sformatf("mul_ovf_m%0d_s%0d", m, s));
                run_one(fp_ops_pkg::OP_MUL, {s[0], 8'h10, 23'h2a5a5a}, 32'h08000000, m,
                        $sformatf("mul_unf_m%0d_s%0d", m, s));
                run_one(fp_ops_pkg::OP_MUL, {s[0], 31'h7f7fffff}, 32'h3f800001, m,
                        $sformatf("mul_max_edge_m%0d_s%0d", m, s));
                run_one(fp_ops_pkg::OP_MUL, {s[0], 31'h00800000}, 32'h3f000000, m,
                        $sformatf("mul_min_half_m%0d_s%0d", m, s));
                run_one(fp_ops_pkg::OP_DIV, {s[0], 8'hf0, 23'h0f0f0f}, 32'h08000000, m,
                        $sformatf("div_ovf_m%0d_s%0d", m, s));
                run_one(fp_ops_pkg::OP_DIV, {s[0], 8'h10, 23'h333333}, 32'h78000000, m,
                        $sformatf("div_unf_m%0d_s%0d", m, s));
            end
        end

        // requests during a division must be dropped
        wait_busy(1'b0, "busy test");
        issue(make_req(fp_ops_pkg::OP_DIV, 32'h40490fdb, 32'h3fb504f3, 0), "div_while_busy");
        release_req();
        wait_busy(1'b1, "busy test");
        issue_ignored(make_req(fp_ops_pkg::OP_MUL, 32'h40000000, 32'h40000000, 0));
        issue_ignored(make_req(fp_ops_pkg::OP_DIV, 32'h3f800000, 32'h40400000, 1));
        release_req();
        wait_drained("busy test");
        repeat (8) @(negedge clk);
        run_one(fp_ops_pkg::OP_MUL, 32'h40400000, 32'hbfc00000, 0, "mul_after_busy");

        $display("errors: %0d value, %0d timeout, %0d protocol",
                 value_errors, timeout_errors, protocol_errors);
        if (value_errors + timeout_errors + protocol_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+design
design/fp_types_pkg.sv
design/fp_ops_pkg.sv
design/fp_unpack.sv
design/fp_mul_core.sv
design/fp_div_core.sv
design/fp_round.sv
design/fp_unit_top.sv
test/tb_clock_gen.sv
test/tb_fp_unit.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fp_unit -f files.f
	./obj_dir/Vtb_fp_unit | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
